// File: Bender.yml
package:
  name: radio_core

sources:
  - include_dirs:
      - design
    files:
      - design/radio_pkg.sv
      - design/radio_regs.sv
      - design/rx_frontend.sv
      - design/pps_timekeeper.sv
      - design/radio_core.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/radio_core_tb.sv

// File: design/pps_timekeeper.sv
/* pps timekeeper */
`timescale 1ns/100ps
`default_nettype none

`include "radio_defs.svh"

module pps_timekeeper
   import radio_pkg::*;
(
   input  wire                          radio_clk,
   input  wire                          i_rst_n,
   input  wire                          i_pps,          // asynchronous
   input  wire  [`RADIO_TIME_W-1:0]     i_time_next,
   input  wire                          i_time_arm,     // single cycle
   output logic                         o_armed,
   output logic [`RADIO_TIME_W-1:0]     o_pps_time,
   output logic [`RADIO_TIME_W-1:0]     o_time_now
);

   localparam int SYNC_N = `RADIO_PPS_SYNC_STAGES;

   logic [SYNC_N-1:0]  pps_sync;      // bit 0 samples the pin
   logic               pps_last;      // previous synced level
   logic               pps_edge;      // registered rising edge

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         pps_sync   <= '0;
         pps_last   <= 1'b0;
         pps_edge   <= 1'b0;
         o_armed    <= 1'b0;
         o_pps_time <= '0;
         o_time_now <= '0;
      end else begin
         pps_sync <= {pps_sync[SYNC_N-2:0], i_pps};
         pps_last <= pps_sync[SYNC_N-1];
         pps_edge <= pps_sync[SYNC_N-1] & ~pps_last;

         if (pps_edge && o_armed) begin
            // armed load, counter and latch both take the preset
            o_time_now <= i_time_next;
            o_pps_time <= i_time_next;
            o_armed    <= 1'b0;
         end else begin
            o_time_now <= o_time_now + 1'b1;
            if (pps_edge) begin
               o_pps_time <= o_time_now;   // free running latch
               o_armed    <= 1'b0;
            end else if (i_time_arm) begin
               o_armed    <= 1'b1;
            end
         end
      end
   end

   // an edge always consumes or blocks the arm
   a_edge_disarms : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      pps_edge |=> !o_armed);

endmodule : pps_timekeeper

`default_nettype wire

// File: design/radio_core.sv
/* radio slot top level */
`timescale 1ns/100ps
`default_nettype none

`include "radio_defs.svh"

module radio_core
   import radio_pkg::*;
(
   input  wire                          radio_clk,
   input  wire                          i_rst_n,
   // wishbone classic slave
   input  wire                          i_wb_cyc,
   input  wire                          i_wb_stb,
   input  wire                          i_wb_we,
   input  wire  [`RADIO_WB_AW-1:0]      i_wb_adr,
   input  wire  [`RADIO_WB_DW-1:0]      i_wb_dat,
   output logic [`RADIO_WB_DW-1:0]      o_wb_dat,
   output logic                         o_wb_ack,
   // adc stream, fanned to both channels
   input  wire  [`RADIO_SAMPLE_W-1:0]   i_rx,
   input  wire                          i_rx_stb,
   output logic [`RADIO_SAMPLE_W-1:0]   o_rx0,
   output logic                         o_rx0_stb,
   output logic [`RADIO_SAMPLE_W-1:0]   o_rx1,
   output logic                         o_rx1_stb,
   // timing and board io
   input  wire                          i_pps,
   output logic [`RADIO_LED_W-1:0]      o_radio_led,
   output logic [`RADIO_WB_DW-1:0]      o_misc_out,
   input  wire  [`RADIO_WB_DW-1:0]      i_misc_in
);

   logic                        ch0_swap;
   logic [`RADIO_SAMPLE_W-1:0]  ch0_offset;
   logic                        ch1_swap;
   logic [`RADIO_SAMPLE_W-1:0]  ch1_offset;
   logic [`RADIO_TIME_W-1:0]    time_next;
   logic                        time_arm;
   logic                        time_armed;
   logic [`RADIO_TIME_W-1:0]    pps_time;
   logic [`RADIO_TIME_W-1:0]    time_now;

   ////////////////////////////////////////////////////////////////////////////
   // control registers
   ////////////////////////////////////////////////////////////////////////////
   radio_regs u_regs (
      .radio_clk    (radio_clk),     .i_rst_n      (i_rst_n),
      .i_wb_cyc     (i_wb_cyc),      .i_wb_stb     (i_wb_stb),
      .i_wb_we      (i_wb_we),       .i_wb_adr     (i_wb_adr),
      .i_wb_dat     (i_wb_dat),      .o_wb_dat     (o_wb_dat),
      .o_wb_ack     (o_wb_ack),
      .i_misc_in    (i_misc_in),     .i_time_armed (time_armed),
      .i_pps_time   (pps_time),      .i_time_now   (time_now),
      .o_ch0_swap   (ch0_swap),      .o_ch0_offset (ch0_offset),
      .o_ch1_swap   (ch1_swap),      .o_ch1_offset (ch1_offset),
      .o_time_next  (time_next),     .o_time_arm   (time_arm),
      .o_misc_out   (o_misc_out),    .o_radio_led  (o_radio_led)
   );

   ////////////////////////////////////////////////////////////////////////////
   // front end correction, one per channel
   ////////////////////////////////////////////////////////////////////////////
   rx_frontend u_rx_fe0 (
      .radio_clk    (radio_clk),     .i_rst_n      (i_rst_n),
      .i_swap       (ch0_swap),      .i_offset     (ch0_offset),
      .i_sample     (i_rx),          .i_sample_stb (i_rx_stb),
      .o_sample     (o_rx0),         .o_sample_stb (o_rx0_stb)
   );

   rx_frontend u_rx_fe1 (
      .radio_clk    (radio_clk),     .i_rst_n      (i_rst_n),
      .i_swap       (ch1_swap),      .i_offset     (ch1_offset),
      .i_sample     (i_rx),          .i_sample_stb (i_rx_stb),   // same adc
      .o_sample     (o_rx1),         .o_sample_stb (o_rx1_stb)
   );

   // time base
   pps_timekeeper u_time (
      .radio_clk    (radio_clk),     .i_rst_n      (i_rst_n),
      .i_pps        (i_pps),         .i_time_next  (time_next),
      .i_time_arm   (time_arm),      .o_armed      (time_armed),
      .o_pps_time   (pps_time),      .o_time_now   (time_now)
   );

endmodule : radio_core

`default_nettype wire

// File: design/radio_defs.svh
/* radio slot widths and constants */

`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// sample stream, I in the upper half and Q in the lower half
`define RADIO_SAMPLE_W         32
`define RADIO_IQ_W             16   // signed component

// wishbone classic slave
`define RADIO_WB_AW            4    // word address
`define RADIO_WB_DW            32

// timekeeping
`define RADIO_TIME_W           32
`define RADIO_PPS_SYNC_STAGES  2

// led bits per channel are {rx, txrx_tx, txrx_rx}
`define RADIO_LED_W            3

`endif

// File: design/radio_pkg.sv
/* radio slot register map */
`default_nettype none

`include "radio_defs.svh"

package radio_pkg;

   // word addresses seen on the wishbone port
   typedef enum logic [`RADIO_WB_AW-1:0] {
      REG_CH0_CTRL   = 0,    // bit 0 swaps I and Q
      REG_CH0_OFFSET = 1,    // {i_offset, q_offset}
      REG_CH1_CTRL   = 2,
      REG_CH1_OFFSET = 3,
      REG_LEDS       = 4,    // ch1 in 5..3, ch0 in 2..0
      REG_MISC_OUT   = 5,
      REG_MISC_IN    = 6,    // read only
      REG_TIME_NEXT  = 7,    // time loaded at next pps
      REG_TIME_CTRL  = 8,    // write 1 to arm, read armed status
      REG_PPS_TIME   = 9,    // read only
      REG_TIME_NOW   = 10    // read only
   } reg_addr_e;

endpackage : radio_pkg

`default_nettype wire

// File: design/radio_regs.sv
/* radio register block */
`timescale 1ns/100ps
`default_nettype none

`include "radio_defs.svh"

module radio_regs
   import radio_pkg::*;
(
   input  wire                          radio_clk,
   input  wire                          i_rst_n,
   // wishbone classic slave
   input  wire                          i_wb_cyc,
   input  wire                          i_wb_stb,
   input  wire                          i_wb_we,
   input  wire  [`RADIO_WB_AW-1:0]      i_wb_adr,
   input  wire  [`RADIO_WB_DW-1:0]      i_wb_dat,
   output logic [`RADIO_WB_DW-1:0]      o_wb_dat,
   output logic                         o_wb_ack,
   // status back from the radio
   input  wire  [`RADIO_WB_DW-1:0]      i_misc_in,
   input  wire                          i_time_armed,
   input  wire  [`RADIO_TIME_W-1:0]     i_pps_time,
   input  wire  [`RADIO_TIME_W-1:0]     i_time_now,
   // front end controls
   output logic                         o_ch0_swap,
   output logic [`RADIO_SAMPLE_W-1:0]   o_ch0_offset,
   output logic                         o_ch1_swap,
   output logic [`RADIO_SAMPLE_W-1:0]   o_ch1_offset,
   // timekeeper controls
   output logic [`RADIO_TIME_W-1:0]     o_time_next,
   output logic                         o_time_arm,    // single cycle
   // board outputs
   output logic [`RADIO_WB_DW-1:0]      o_misc_out,
   output logic [`RADIO_LED_W-1:0]      o_radio_led
);

   localparam int LED_W = `RADIO_LED_W;

   logic                        wb_req;         // first cycle of a transfer
   logic                        wb_wr;
   reg_addr_e                   wb_addr;
   logic [`RADIO_WB_DW-1:0]     rd_data;
   logic [2*LED_W-1:0]          led_reg;        // both channel fields
   logic [`RADIO_WB_DW-1:0]     misc_out_reg;
   logic [`RADIO_WB_DW-1:0]     misc_in_r;

   assign wb_req  = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // ack low, so not yet served
   assign wb_wr   = wb_req & i_wb_we;
   assign wb_addr = reg_addr_e'(i_wb_adr);

   ////////////////////////////////////////////////////////////////////////////
   // readback mux
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_data = '0;
      case (wb_addr)
         REG_CH0_CTRL:   rd_data[0] = o_ch0_swap;
         REG_CH0_OFFSET: rd_data = o_ch0_offset;
         REG_CH1_CTRL:   rd_data[0] = o_ch1_swap;
         REG_CH1_OFFSET: rd_data = o_ch1_offset;
         REG_LEDS:       rd_data[2*LED_W-1:0] = led_reg;
         REG_MISC_OUT:   rd_data = misc_out_reg;
         REG_MISC_IN:    rd_data = misc_in_r;
         REG_TIME_NEXT:  rd_data = o_time_next;
         REG_TIME_CTRL:  rd_data[0] = i_time_armed;
         REG_PPS_TIME:   rd_data = i_pps_time;
         REG_TIME_NOW:   rd_data = i_time_now;
         default:        rd_data = '0;          // unmapped
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // handshake and register writes
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_wb_ack     <= 1'b0;
         o_ch0_swap   <= 1'b0;
         o_ch0_offset <= '0;
         o_ch1_swap   <= 1'b0;
         o_ch1_offset <= '0;
         o_time_next  <= '0;
         o_time_arm   <= 1'b0;
         led_reg      <= '0;
         misc_out_reg <= '0;
         o_misc_out   <= '0;
         o_radio_led  <= '0;
         misc_in_r    <= '0;
      end else begin
         o_wb_ack   <= wb_req;      // one cycle after stb
         o_time_arm <= 1'b0;
         if (wb_wr) begin
            case (wb_addr)
               REG_CH0_CTRL:   o_ch0_swap   <= i_wb_dat[0];
               REG_CH0_OFFSET: o_ch0_offset <= i_wb_dat;
               REG_CH1_CTRL:   o_ch1_swap   <= i_wb_dat[0];
               REG_CH1_OFFSET: o_ch1_offset <= i_wb_dat;
               REG_LEDS:       led_reg      <= i_wb_dat[2*LED_W-1:0];
               REG_MISC_OUT:   misc_out_reg <= i_wb_dat;
               REG_TIME_NEXT:  o_time_next  <= i_wb_dat;
               REG_TIME_CTRL:  o_time_arm   <= i_wb_dat[0];   // arm only on a 1
               default: ;                                     // read only or unmapped
            endcase
         end
         o_misc_out  <= misc_out_reg;
         // both channels lit as one overlay
         o_radio_led <= led_reg[LED_W-1:0] | led_reg[2*LED_W-1:LED_W];
         misc_in_r   <= i_misc_in;
      end
   end

   // read data held while ack is high
   always_ff @(posedge radio_clk) begin
      if (wb_req) begin
         o_wb_dat <= rd_data;
      end
   end

   // ack is a single pulse per transfer
   a_ack_pulse : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_wb_ack |=> !o_wb_ack);

   // ack only answers a request seen on the previous edge
   a_ack_req : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_wb_ack |-> $past(i_wb_cyc && i_wb_stb));

endmodule : radio_regs

`default_nettype wire

// File: design/rx_frontend.sv
/* rx front end correction */
`timescale 1ns/100ps
`default_nettype none

`include "radio_defs.svh"

module rx_frontend
   import radio_pkg::*;
(
   input  wire                          radio_clk,
   input  wire                          i_rst_n,
   input  wire                          i_swap,
   input  wire  [`RADIO_SAMPLE_W-1:0]   i_offset,      // {i_off, q_off}
   input  wire  [`RADIO_SAMPLE_W-1:0]   i_sample,      // {i, q}
   input  wire                          i_sample_stb,
   output logic [`RADIO_SAMPLE_W-1:0]   o_sample,
   output logic                         o_sample_stb
);

   localparam int IQ_W = `RADIO_IQ_W;

   logic [`RADIO_SAMPLE_W-1:0]  s1_sample;     // after swap
   logic                        s1_stb;
   logic signed [IQ_W:0]        sum_i;         // one guard bit
   logic signed [IQ_W:0]        sum_q;

   // clamp a guarded sum back to IQ_W bits
   function automatic logic [IQ_W-1:0] sat_iq(input logic signed [IQ_W:0] v);
      logic [IQ_W-1:0] res;
      if (v[IQ_W] != v[IQ_W-1]) begin
         res = {v[IQ_W], {(IQ_W-1){~v[IQ_W]}}};   // full scale, sign kept
      end else begin
         res = v[IQ_W-1:0];
      end
      return res;
   endfunction

   // sign extended adds, cannot wrap in IQ_W+1 bits
   assign sum_i = $signed({s1_sample[2*IQ_W-1], s1_sample[2*IQ_W-1:IQ_W]})
                + $signed({i_offset[2*IQ_W-1], i_offset[2*IQ_W-1:IQ_W]});
   assign sum_q = $signed({s1_sample[IQ_W-1], s1_sample[IQ_W-1:0]})
                + $signed({i_offset[IQ_W-1], i_offset[IQ_W-1:0]});

   // strobe pipe
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         s1_stb       <= 1'b0;
         o_sample_stb <= 1'b0;
      end else begin
         s1_stb       <= i_sample_stb;
         o_sample_stb <= s1_stb;
      end
   end

   // data pipe, loads only on strobe
   always_ff @(posedge radio_clk) begin
      if (i_sample_stb) begin
         s1_sample <= i_swap ? {i_sample[IQ_W-1:0], i_sample[2*IQ_W-1:IQ_W]} : i_sample;
      end
      if (s1_stb) begin
         o_sample <= {sat_iq(sum_i), sat_iq(sum_q)};
      end
   end

   // two stages from input strobe to output strobe
   a_stb_latency : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_sample_stb |-> $past(i_sample_stb, 2));

endmodule : rx_frontend

`default_nettype wire

// File: list.f
+incdir+design
+incdir+tests
design/radio_pkg.sv
design/radio_regs.sv
design/rx_frontend.sv
design/pps_timekeeper.sv
design/radio_core.sv
tests/radio_core_tb.sv

// File: tests/radio_ref.svh
/* radio slot reference models */

`ifndef RADIO_REF_SVH
`define RADIO_REF_SVH

// signed 16 bit full scale limits
function automatic logic [15:0] clamp_iq(input int v);
   if (v > 32767) begin
      return 16'h7fff;
   end else if (v < -32768) begin
      return 16'h8000;
   end
   return 16'(v);
endfunction

// expected front end output, swap first and then offset with clamp
function automatic logic [31:0] ref_correct(input logic [31:0] s, input logic swap,
                                             input logic [31:0] off);
   shortint si;
   shortint sq;
   shortint oi;
   shortint oq;
   si = swap ? s[15:0] : s[31:16];   // I lives in the upper half
   sq = swap ? s[31:16] : s[15:0];
   oi = off[31:16];
   oq = off[15:0];
   return {clamp_iq(int'(si) + int'(oi)), clamp_iq(int'(sq) + int'(oq))};
endfunction

// leds of ch0 in 2..0 and ch1 in 5..3, lit when either asks
function automatic logic [2:0] ref_led_merge(input logic [5:0] leds);
   return leds[2:0] | leds[5:3];
endfunction

`endif

// File: tests/radio_core_tb.sv
/* radio slot testbench */
`timescale 1ns/100ps
`default_nettype none

`include "radio_defs.svh"

module radio_core_tb
   import radio_pkg::*;
();

   `include "radio_ref.svh"

   logic          radio_clk;
   logic          i_rst_n;
   logic          i_wb_cyc;
   logic          i_wb_stb;
   logic          i_wb_we;
   logic [3:0]    i_wb_adr;
   logic [31:0]   i_wb_dat;
   logic [31:0]   o_wb_dat;
   logic          o_wb_ack;
   logic [31:0]   i_rx;
   logic          i_rx_stb;
   logic [31:0]   o_rx0;
   logic          o_rx0_stb;
   logic [31:0]   o_rx1;
   logic          o_rx1_stb;
   logic          i_pps;
   logic [2:0]    o_radio_led;
   logic [31:0]   o_misc_out;
   logic [31:0]   i_misc_in;

   logic [31:0]   exp0_q[$];        // expected o_rx0 with the oldest first
   logic [31:0]   exp1_q[$];
   logic          swap0;
   logic          swap1;
   logic [31:0]   off0;
   logic [31:0]   off1;
   int unsigned   cycle_cnt;
   int            errors;
   int            err_mark;
   int            tests_run;
   int            tests_failed;

   radio_core uut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #10 radio_clk = ~radio_clk;
   end

   always @(posedge radio_clk) cycle_cnt <= cycle_cnt + 1;   // pps spacing ruler

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic abort_run(input string what);
      $display("Timeout: %s", what);
      $display("Regression failed");
      $finish;
   endtask

   // one classic transfer with ack sampled at the falling edge
   task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
      int n;
      @(posedge radio_clk);
      #2;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = adr;
      i_wb_dat = wdat;
      n = 0;
      do begin
         @(negedge radio_clk);
         n++;
      end while (!o_wb_ack && n < 8);
      if (!o_wb_ack) abort_run("no wishbone ack");
      rdat = o_wb_dat;
      @(posedge radio_clk);
      #2;
      i_wb_cyc = 1'b0;   // drop stb after ack
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      wb_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
      wb_cycle(1'b0, adr, 32'h0, dat);
   endtask

   // components biased toward full scale
   function automatic logic [15:0] rand_iq();
      case ($urandom % 4)
         0:       return 16'h7fff - 16'($urandom % 8);
         1:       return 16'h8000 + 16'($urandom % 8);
         default: return 16'($urandom);
      endcase
   endfunction

   task automatic run_stream(input int count);
      logic [31:0] s;
      int sent;
      int n;
      sent = 0;
      while (sent < count) begin
         @(posedge radio_clk);
         #2;
         i_rx_stb = ($urandom % 4) != 0;    // mostly back to back
         if (i_rx_stb) begin
            s    = {rand_iq(), rand_iq()};
            i_rx = s;
            exp0_q.push_back(ref_correct(s, swap0, off0));
            exp1_q.push_back(ref_correct(s, swap1, off1));
            sent++;
         end
      end
      @(posedge radio_clk);
      #2;
      i_rx_stb = 1'b0;
      n = 0;
      while ((exp0_q.size() != 0 || exp1_q.size() != 0) && n < 20) begin
         @(posedge radio_clk);
         n++;
      end
      if (exp0_q.size() != 0 || exp1_q.size() != 0) abort_run("samples did not emerge");
   endtask

   task automatic pps_pulse(output int unsigned rise);
      @(posedge radio_clk);
      #2;
      i_pps = 1'b1;
      rise  = cycle_cnt;
      repeat (2) @(posedge radio_clk);
      #2;
      i_pps = 1'b0;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // output stream checker
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      forever begin
         @(negedge radio_clk);
         if (o_rx0_stb) begin
            assert (exp0_q.size() != 0) else begin
               $display("o_rx0 strobe with no sample pending");
               errors++;
            end
            if (exp0_q.size() != 0) check_value("o_rx0", o_rx0, exp0_q.pop_front());
         end
         if (o_rx1_stb) begin
            assert (exp1_q.size() != 0) else begin
               $display("o_rx1 strobe with no sample pending");
               errors++;
            end
            if (exp1_q.size() != 0) check_value("o_rx1", o_rx1, exp1_q.pop_front());
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [3:0]    rw_adr  [7];
      logic [31:0]   rw_mask [7];
      logic [31:0]   wr_val  [7];
      logic [31:0]   rd;
      logic [31:0]   t_next;
      logic [31:0]   p1;
      logic [31:0]   p2;
      int unsigned   r1;
      int unsigned   r2;
      int            a;
      int            n;
      rw_adr    = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd7};
      rw_mask   = '{32'h1, '1, 32'h1, '1, 32'h3f, '1, '1};   // bits each register keeps
      i_rst_n   = 1'b0;
      i_wb_cyc  = 1'b0;
      i_wb_stb  = 1'b0;
      i_wb_we   = 1'b0;
      i_wb_adr  = '0;
      i_wb_dat  = '0;
      i_rx      = '0;
      i_rx_stb  = 1'b0;
      i_pps     = 1'b0;
      i_misc_in = '0;
      cycle_cnt = 0;
      errors    = 0;
      err_mark  = 0;
      tests_run = 0;
      tests_failed = 0;
      a = $urandom(21673);
      repeat (3) @(posedge radio_clk);
      #2;
      i_rst_n = 1'b1;

      // zero after reset then random readback
      for (a = 0; a < 16; a++) begin
         if (a != REG_TIME_NOW) begin
            wb_read(4'(a), rd);
            check_value($sformatf("o_wb_dat[adr %0d]", a), rd, 32'h0);
         end
      end
      for (a = 0; a < 7; a++) begin
         wr_val[a] = $urandom;
         wb_write(rw_adr[a], wr_val[a]);
      end
      for (a = 0; a < 7; a++) begin
         wb_read(rw_adr[a], rd);
         check_value($sformatf("o_wb_dat[adr %0d]", rw_adr[a]), rd, wr_val[a] & rw_mask[a]);
      end
      wb_write(4'd13, $urandom);   // unmapped
      wb_read(4'd13, rd);
      check_value("o_wb_dat[adr 13]", rd, 32'h0);
      end_test("register access");

      // channels set apart by their swap
      for (a = 0; a < 2; a++) begin
         swap0 = $urandom % 2;
         swap1 = ~swap0;
         off0  = $urandom;
         off1  = $urandom;
         wb_write(REG_CH0_CTRL, {31'h0, swap0});
         wb_write(REG_CH0_OFFSET, off0);
         wb_write(REG_CH1_CTRL, {31'h0, swap1});
         wb_write(REG_CH1_OFFSET, off1);
         run_stream(40);
      end
      end_test("correction path");

      // led overlay and misc words
      for (a = 0; a < 4; a++) begin
         wr_val[0] = $urandom % 64;
         wr_val[1] = $urandom;
         wb_write(REG_LEDS, wr_val[0]);
         @(negedge radio_clk);
         check_value("o_radio_led", o_radio_led, ref_led_merge(wr_val[0][5:0]));
         wb_write(REG_MISC_OUT, wr_val[1]);
         @(negedge radio_clk);
         check_value("o_misc_out", o_misc_out, wr_val[1]);
         @(posedge radio_clk);
         #2;
         i_misc_in = $urandom;
         repeat (3) @(posedge radio_clk);
         wb_read(REG_MISC_IN, rd);
         check_value("o_wb_dat[REG_MISC_IN]", rd, i_misc_in);
      end
      end_test("led and misc");

      // preset kept below half range so later latches do not wrap
      t_next = $urandom >> 1;
      wb_write(REG_TIME_NEXT, t_next);
      wb_write(REG_TIME_CTRL, 32'h1);
      wb_read(REG_TIME_CTRL, rd);
      check_value("o_wb_dat[REG_TIME_CTRL]", rd, 32'h1);
      @(posedge radio_clk);
      #2;
      i_pps = 1'b1;
      n = 0;
      do begin
         wb_read(REG_TIME_CTRL, rd);
         n++;
      end while (rd[0] && n < 10);
      i_pps = 1'b0;
      if (rd[0]) abort_run("time load never disarmed");
      wb_read(REG_PPS_TIME, rd);
      check_value("o_wb_dat[REG_PPS_TIME]", rd, t_next);
      end_test("armed time load");

      // free running latch
      pps_pulse(r1);
      repeat (4) @(posedge radio_clk);    // sync, edge and latch
      wb_read(REG_PPS_TIME, p1);
      wb_read(REG_TIME_NOW, rd);
      assert (p1 <= rd) else begin
         $display("** Error: REG_PPS_TIME %h above REG_TIME_NOW %h", p1, rd);
         errors++;
      end
      repeat ($urandom % 20) @(posedge radio_clk);
      pps_pulse(r2);
      repeat (4) @(posedge radio_clk);
      wb_read(REG_PPS_TIME, p2);
      check_value("REG_PPS_TIME delta", p2 - p1, r2 - r1);
      end_test("free running latch");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule : radio_core_tb

`default_nettype wire
